/* common/tage_pkg.sv */
package tage_pkg;

	localparam int PC_W = 16;
	localparam int GHIST_W = 32;
	localparam int TIDX_W = 6;
	localparam int TAG_W = 8;
	localparam int BIDX_W = 8;
	localparam int CTR_W = 3;
	localparam int BCTR_W = 2;
	localparam int U_W = 2;
	localparam int PROV_W = 3;

	localparam int NUM_TABLES = 4;
	localparam int TAGGED_ENTRIES = 1 << TIDX_W;
	localparam int BASE_ENTRIES = 1 << BIDX_W;

	// entry 0 belongs to tagged table 1
	localparam int HIST_LEN [NUM_TABLES] = '{4, 8, 16, 32};

	typedef logic [PC_W-1:0] pc_t;
	typedef logic [GHIST_W-1:0] ghist_t;
	typedef logic [TIDX_W-1:0] tidx_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [BIDX_W-1:0] bidx_t;
	typedef logic [CTR_W-1:0] ctr_t;
	typedef logic [BCTR_W-1:0] bctr_t;
	typedef logic [U_W-1:0] u_t;
	typedef logic [PROV_W-1:0] prov_t;

	// signed counter limits, non-negative predicts taken
	localparam ctr_t CTR_MAX = 3'b011;
	localparam ctr_t CTR_MIN = 3'b100;
	localparam ctr_t CTR_WEAK_TAKEN = 3'b000;
	localparam ctr_t CTR_WEAK_NOT_TAKEN = 3'b111;

	localparam bctr_t BCTR_INIT = 2'b01;
	localparam bctr_t BCTR_MAX = 2'b11;
	localparam u_t U_MAX = 2'b11;

	typedef enum logic [2:0] {
		IDLE,
		LOOKUP_READ,
		LOOKUP_ACK,
		UPDATE_READ,
		UPDATE_WRITE,
		UPDATE_ACK
	} ctrl_state_t;

endpackage

/* design/tage_index_gen.sv */
`timescale 1ns/1ps

module tage_index_gen import tage_pkg::*; (
	input logic clk,
	input logic reset,
	input pc_t rd_pc,
	input logic hist_shift_en,
	input logic hist_bit,
	output tidx_t [NUM_TABLES-1:0] rd_idx,
	output tag_t [NUM_TABLES-1:0] rd_tag,
	output bidx_t base_idx
);

	ghist_t ghist;

	// xor of w-bit chunks over the youngest len bits
	function automatic logic [7:0] fold(ghist_t h, int len, int w);
		logic [7:0] f;
		f = '0;
		for (int i = 0; i < GHIST_W; i++) begin
			if (i < len) begin
				f[i % w] = f[i % w] ^ h[i];
			end
		end
		return f;
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			ghist <= '0;
		end else if (hist_shift_en) begin
			ghist <= {ghist[GHIST_W-2:0], hist_bit};
		end
	end

	for (genvar t = 0; t < NUM_TABLES; t++) begin : g_hash
		logic [7:0] idx_fold;
		logic [7:0] tag_fold;

		assign idx_fold = fold(ghist, HIST_LEN[t], TIDX_W);
		assign tag_fold = fold(ghist, HIST_LEN[t], TAG_W);

		assign rd_idx[t] = rd_pc[5:0] ^ rd_pc[11:6] ^ tidx_t'(idx_fold);
		// table number mixed in so equal folds still give distinct tags
		assign rd_tag[t] = rd_pc[15:8] ^ tag_t'(tag_fold) ^ tag_t'(t + 1);
	end

	assign base_idx = rd_pc[7:0];

endmodule

/* tage_table/tage_tagged_table.sv */
`timescale 1ns/1ps

module tage_tagged_table import tage_pkg::*; #(
	parameter int TABLE_NUM = 1
) (
	input logic clk,
	input logic reset,
	input logic rd_en,
	input tidx_t idx,
	input tag_t tag,
	output logic hit,
	output ctr_t ctr,
	output u_t u,
	input logic we_ctr,
	input logic we_u,
	input logic alloc,
	input ctr_t wr_ctr,
	input u_t wr_u
);

	logic [TAGGED_ENTRIES-1:0] valid_arr;
	tag_t tag_arr [TAGGED_ENTRIES];
	ctr_t ctr_arr [TAGGED_ENTRIES];
	u_t u_arr [TAGGED_ENTRIES];

	tidx_t idx_q;
	tag_t tag_q;

	// read address held for the write that follows
	always_ff @(posedge clk) begin
		if (rd_en) begin
			idx_q <= idx;
			tag_q <= tag;
		end
	end

	assign hit = valid_arr[idx_q] && (tag_arr[idx_q] == tag_q);
	assign ctr = ctr_arr[idx_q];
	assign u = u_arr[idx_q];

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_arr <= '0;
			for (int i = 0; i < TAGGED_ENTRIES; i++) begin
				u_arr[i] <= '0;
			end
		end else begin
			if (alloc) begin
				valid_arr[idx_q] <= 1'b1;
			end
			if (we_u) begin
				u_arr[idx_q] <= wr_u;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (we_ctr) begin
			ctr_arr[idx_q] <= wr_ctr;
		end
		if (alloc) begin
			tag_arr[idx_q] <= tag_q;
		end
	end

	// a new entry must always get its initial counter
	assert property (@(posedge clk) disable iff (reset) alloc |-> we_ctr)
		else $error("table %0d: alloc without counter write", TABLE_NUM);

endmodule

/* design/tage_base_table.sv */
`timescale 1ns/1ps

module tage_base_table import tage_pkg::*; (
	input logic clk,
	input logic reset,
	input logic rd_en,
	input bidx_t idx,
	output bctr_t bctr,
	input logic we,
	input logic taken
);

	bctr_t mem [BASE_ENTRIES];
	bidx_t idx_q;

	always_ff @(posedge clk) begin
		if (rd_en) begin
			idx_q <= idx;
		end
	end

	assign bctr = mem[idx_q];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < BASE_ENTRIES; i++) begin
				mem[i] <= BCTR_INIT;
			end
		end else if (we) begin
			// saturate toward the outcome
			if (taken && mem[idx_q] != BCTR_MAX) begin
				mem[idx_q] <= mem[idx_q] + 1'b1;
			end else if (!taken && mem[idx_q] != '0) begin
				mem[idx_q] <= mem[idx_q] - 1'b1;
			end
		end
	end

endmodule

/* design/tage_provider_select.sv */
`timescale 1ns/1ps

module tage_provider_select import tage_pkg::*; (
	input logic [NUM_TABLES-1:0] hit,
	input ctr_t [NUM_TABLES-1:0] ctr,
	input bctr_t base_bctr,
	output prov_t provider,
	output logic provider_taken,
	output logic alt_taken,
	output ctr_t provider_ctr
);

	logic base_taken;

	assign base_taken = base_bctr[BCTR_W-1];

	// walk upward so the longest hit wins and the previous winner
	// becomes the alternate
	always_comb begin
		provider = '0;
		provider_taken = base_taken;
		alt_taken = base_taken;
		provider_ctr = '0;
		for (int i = 0; i < NUM_TABLES; i++) begin
			if (hit[i]) begin
				alt_taken = provider_taken;
				provider = prov_t'(i + 1);
				provider_taken = ~ctr[i][CTR_W-1];
				provider_ctr = ctr[i];
			end
		end
	end

endmodule

/* design/tage_update_ctrl.sv */
`timescale 1ns/1ps

module tage_update_ctrl import tage_pkg::*; (
	input logic clk,
	input logic reset,
	input logic lookup_req,
	input pc_t lookup_pc,
	output logic lookup_ack,
	output logic pred_taken,
	output prov_t pred_provider,
	input logic update_req,
	input pc_t update_pc,
	input logic update_taken,
	output logic update_ack,
	output pc_t rd_pc,
	output logic rd_en,
	input prov_t provider,
	input logic provider_taken,
	input logic alt_taken,
	input ctr_t provider_ctr,
	input u_t [NUM_TABLES-1:0] u,
	output logic [NUM_TABLES-1:0] we_ctr,
	output logic [NUM_TABLES-1:0] we_u,
	output logic [NUM_TABLES-1:0] alloc,
	output ctr_t [NUM_TABLES-1:0] wr_ctr,
	output u_t [NUM_TABLES-1:0] wr_u,
	output logic base_we,
	output logic hist_shift_en,
	output logic hist_bit
);

	ctrl_state_t state;
	logic mispredict;

	function automatic ctr_t ctr_step(ctr_t c, logic up);
		if (up) begin
			return (c == CTR_MAX) ? c : c + 1'b1;
		end
		return (c == CTR_MIN) ? c : c - 1'b1;
	endfunction

	function automatic u_t u_step(u_t v, logic up);
		if (up) begin
			return (v == U_MAX) ? v : v + 1'b1;
		end
		return (v == '0) ? v : v - 1'b1;
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			lookup_ack <= 1'b0;
			update_ack <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					// lookup has priority
					if (lookup_req) begin
						state <= LOOKUP_READ;
					end else if (update_req) begin
						state <= UPDATE_READ;
					end
				end
				LOOKUP_READ: state <= LOOKUP_ACK;
				LOOKUP_ACK: begin
					if (!lookup_ack) begin
						lookup_ack <= 1'b1;
					end else if (!lookup_req) begin
						lookup_ack <= 1'b0;
						state <= IDLE;
					end
				end
				UPDATE_READ: state <= UPDATE_WRITE;
				UPDATE_WRITE: state <= UPDATE_ACK;
				UPDATE_ACK: begin
					if (!update_ack) begin
						update_ack <= 1'b1;
					end else if (!update_req) begin
						update_ack <= 1'b0;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// prediction held for the whole ack phase
	always_ff @(posedge clk) begin
		if (state == LOOKUP_ACK && !lookup_ack) begin
			pred_taken <= provider_taken;
			pred_provider <= provider;
		end
	end

	assign rd_en = (state == LOOKUP_READ) || (state == UPDATE_READ);
	assign rd_pc = (state == LOOKUP_READ) ? lookup_pc : update_pc;
	assign hist_shift_en = (state == UPDATE_WRITE);
	assign hist_bit = update_taken;
	assign mispredict = provider_taken != update_taken;

	always_comb begin : write_logic
		logic found;
		found = 1'b0;
		we_ctr = '0;
		we_u = '0;
		alloc = '0;
		wr_ctr = '0;
		wr_u = '0;
		base_we = 1'b0;
		if (state == UPDATE_WRITE) begin
			base_we = (provider == '0);
			for (int i = 0; i < NUM_TABLES; i++) begin
				if (int'(provider) == i + 1) begin
					we_ctr[i] = 1'b1;
					wr_ctr[i] = ctr_step(provider_ctr, update_taken);
					// usefulness only moves when alt disagrees
					if (provider_taken != alt_taken) begin
						we_u[i] = 1'b1;
						wr_u[i] = u_step(u[i], !mispredict);
					end
				end
			end
			if (mispredict && int'(provider) < NUM_TABLES) begin
				for (int i = 0; i < NUM_TABLES; i++) begin
					if (i >= int'(provider) && !found && u[i] == '0) begin
						found = 1'b1;
						alloc[i] = 1'b1;
						we_ctr[i] = 1'b1;
						we_u[i] = 1'b1;
						wr_ctr[i] = update_taken ? CTR_WEAK_TAKEN : CTR_WEAK_NOT_TAKEN;
						wr_u[i] = '0;
					end
				end
				// no free slot, age every longer table instead
				if (!found) begin
					for (int i = 0; i < NUM_TABLES; i++) begin
						if (i >= int'(provider)) begin
							we_u[i] = 1'b1;
							wr_u[i] = u_step(u[i], 1'b0);
						end
					end
				end
			end
		end
	end

	assert property (@(posedge clk) disable iff (reset) $onehot0(alloc))
		else $error("more than one table allocated");

	assert property (@(posedge clk) disable iff (reset) !(lookup_ack && update_ack))
		else $error("both acks high");

	assert property (@(posedge clk) disable iff (reset)
		(state == IDLE) |=> !$rose(lookup_ack) && !$rose(update_ack))
		else $error("ack rose out of idle");

endmodule

/* design/tage_top.sv */
`timescale 1ns/1ps

module tage_top import tage_pkg::*; (
	input logic clk,
	input logic reset,
	input logic lookup_req,
	input pc_t lookup_pc,
	output logic lookup_ack,
	output logic pred_taken,
	output prov_t pred_provider,
	input logic update_req,
	input pc_t update_pc,
	input logic update_taken,
	output logic update_ack
);

	pc_t rd_pc;
	logic rd_en;
	tidx_t [NUM_TABLES-1:0] rd_idx;
	tag_t [NUM_TABLES-1:0] rd_tag;
	bidx_t base_idx;
	logic hist_shift_en;
	logic hist_bit;

	logic [NUM_TABLES-1:0] hit;
	ctr_t [NUM_TABLES-1:0] ctr;
	u_t [NUM_TABLES-1:0] u;
	bctr_t base_bctr;

	logic [NUM_TABLES-1:0] we_ctr;
	logic [NUM_TABLES-1:0] we_u;
	logic [NUM_TABLES-1:0] alloc;
	ctr_t [NUM_TABLES-1:0] wr_ctr;
	u_t [NUM_TABLES-1:0] wr_u;
	logic base_we;

	prov_t provider;
	logic provider_taken;
	logic alt_taken;
	ctr_t provider_ctr;

	tage_index_gen index_gen_inst (
		.clk(clk),
		.reset(reset),
		.rd_pc(rd_pc),
		.hist_shift_en(hist_shift_en),
		.hist_bit(hist_bit),
		.rd_idx(rd_idx),
		.rd_tag(rd_tag),
		.base_idx(base_idx)
	);

	for (genvar t = 0; t < NUM_TABLES; t++) begin : g_table
		tage_tagged_table #(
			.TABLE_NUM(t + 1)
		) table_inst (
			.clk(clk),
			.reset(reset),
			.rd_en(rd_en),
			.idx(rd_idx[t]),
			.tag(rd_tag[t]),
			.hit(hit[t]),
			.ctr(ctr[t]),
			.u(u[t]),
			.we_ctr(we_ctr[t]),
			.we_u(we_u[t]),
			.alloc(alloc[t]),
			.wr_ctr(wr_ctr[t]),
			.wr_u(wr_u[t])
		);
	end

	// base trains on the resolved outcome, same bit as the history
	tage_base_table base_table_inst (
		.clk(clk),
		.reset(reset),
		.rd_en(rd_en),
		.idx(base_idx),
		.bctr(base_bctr),
		.we(base_we),
		.taken(hist_bit)
	);

	tage_provider_select provider_select_inst (
		.hit(hit),
		.ctr(ctr),
		.base_bctr(base_bctr),
		.provider(provider),
		.provider_taken(provider_taken),
		.alt_taken(alt_taken),
		.provider_ctr(provider_ctr)
	);

	tage_update_ctrl update_ctrl_inst (
		.clk(clk),
		.reset(reset),
		.lookup_req(lookup_req),
		.lookup_pc(lookup_pc),
		.lookup_ack(lookup_ack),
		.pred_taken(pred_taken),
		.pred_provider(pred_provider),
		.update_req(update_req),
		.update_pc(update_pc),
		.update_taken(update_taken),
		.update_ack(update_ack),
		.rd_pc(rd_pc),
		.rd_en(rd_en),
		.provider(provider),
		.provider_taken(provider_taken),
		.alt_taken(alt_taken),
		.provider_ctr(provider_ctr),
		.u(u),
		.we_ctr(we_ctr),
		.we_u(we_u),
		.alloc(alloc),
		.wr_ctr(wr_ctr),
		.wr_u(wr_u),
		.base_we(base_we),
		.hist_shift_en(hist_shift_en),
		.hist_bit(hist_bit)
	);

endmodule

/* verif/tage_tb.sv */
`timescale 1ns/1ps

module tage_tb import tage_pkg::*; ();

	localparam int WAIT_LIMIT = 50;
	localparam int POOL_SIZE = 6;

	logic clk;
	logic reset;
	logic lookup_req;
	pc_t lookup_pc;
	logic lookup_ack;
	logic pred_taken;
	prov_t pred_provider;
	logic update_req;
	pc_t update_pc;
	logic update_taken;
	logic update_ack;

	int error_count;
	int timeout_count;
	int lookups_checked;
	int alloc_count;
	int decay_count;
	logic [31:0] rng_state;
	logic exp_taken;
	prov_t exp_provider;
	pc_t pc_pool [POOL_SIZE];

	// reference state
	logic [31:0] m_ghist;
	logic m_valid [NUM_TABLES][TAGGED_ENTRIES];
	tag_t m_tag [NUM_TABLES][TAGGED_ENTRIES];
	ctr_t m_ctr [NUM_TABLES][TAGGED_ENTRIES];
	u_t m_u [NUM_TABLES][TAGGED_ENTRIES];
	bctr_t m_base [BASE_ENTRIES];

	tage_top tage_top_inst (
		.clk(clk),
		.reset(reset),
		.lookup_req(lookup_req),
		.lookup_pc(lookup_pc),
		.lookup_ack(lookup_ack),
		.pred_taken(pred_taken),
		.pred_provider(pred_provider),
		.update_req(update_req),
		.update_pc(update_pc),
		.update_taken(update_taken),
		.update_ack(update_ack)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		error_count++;
		$display("[ERROR] %s expected 0x%0h got 0x%0h at %0t", name, exp, got, $time);
	endtask

	task automatic report_text(input string msg);
		error_count++;
		$display("%0t: %s", $time, msg);
	endtask

	// xor of the w-bit chunks of the youngest len bits
	function automatic logic [7:0] fold_hist(logic [31:0] h, int len, int w);
		logic [7:0] acc;
		logic [7:0] mask;
		logic [31:0] kept;
		acc = '0;
		mask = (w >= 8) ? 8'hff : 8'((32'd1 << w) - 32'd1);
		kept = (len >= 32) ? h : (h & ((32'd1 << len) - 32'd1));
		for (int c = 0; c < len; c += w) begin
			acc = acc ^ (8'(kept >> c) & mask);
		end
		return acc;
	endfunction

	function automatic tidx_t model_index(int t, pc_t pc);
		logic [7:0] f;
		f = fold_hist(m_ghist, HIST_LEN[t], TIDX_W);
		return pc[5:0] ^ pc[11:6] ^ f[5:0];
	endfunction

	function automatic tag_t model_tag(int t, pc_t pc);
		return pc[15:8] ^ fold_hist(m_ghist, HIST_LEN[t], TAG_W) ^ tag_t'(t + 1);
	endfunction

	function automatic logic model_hit(int t, pc_t pc);
		tidx_t i;
		i = model_index(t, pc);
		return m_valid[t][i] && (m_tag[t][i] == model_tag(t, pc));
	endfunction

	function automatic logic table_taken(prov_t p, pc_t pc);
		int t;
		t = int'(p) - 1;
		if (p == '0) begin
			return m_base[pc[7:0]][1];
		end
		return !m_ctr[t][model_index(t, pc)][2];
	endfunction

	function automatic ctr_t sat_ctr(ctr_t c, logic up);
		if (up && c != 3'b011) begin
			return c + 3'd1;
		end
		if (!up && c != 3'b100) begin
			return c - 3'd1;
		end
		return c;
	endfunction

	// two-bit unsigned saturating counter, used for u and base
	function automatic logic [1:0] sat2(logic [1:0] v, logic up);
		if (up && v != 2'b11) begin
			return v + 2'd1;
		end
		if (!up && v != 2'b00) begin
			return v - 2'd1;
		end
		return v;
	endfunction

	task automatic model_select(input pc_t pc, output prov_t prov, output logic ptaken,
			output logic ataken);
		prov_t alt;
		prov = '0;
		alt = '0;
		// search from the longest history down
		for (int t = NUM_TABLES - 1; t >= 0; t--) begin
			if (model_hit(t, pc)) begin
				if (prov == '0) begin
					prov = prov_t'(t + 1);
				end else if (alt == '0) begin
					alt = prov_t'(t + 1);
				end
			end
		end
		ptaken = table_taken(prov, pc);
		ataken = table_taken(alt, pc);
	endtask

	task automatic model_update(input pc_t pc, input logic taken);
		prov_t prov;
		logic ptaken;
		logic ataken;
		int p;
		tidx_t i;
		logic found;
		model_select(pc, prov, ptaken, ataken);
		p = int'(prov);
		if (p == 0) begin
			m_base[pc[7:0]] = sat2(m_base[pc[7:0]], taken);
		end else begin
			i = model_index(p - 1, pc);
			m_ctr[p-1][i] = sat_ctr(m_ctr[p-1][i], taken);
			if (ptaken != ataken) begin
				m_u[p-1][i] = sat2(m_u[p-1][i], ptaken == taken);
			end
		end
		if (ptaken != taken && p < NUM_TABLES) begin
			found = 1'b0;
			for (int t = p; t < NUM_TABLES; t++) begin
				i = model_index(t, pc);
				if (!found && m_u[t][i] == '0) begin
					found = 1'b1;
					m_valid[t][i] = 1'b1;
					m_tag[t][i] = model_tag(t, pc);
					m_ctr[t][i] = taken ? 3'b000 : 3'b111;
					m_u[t][i] = '0;
					alloc_count++;
				end
			end
			if (!found) begin
				decay_count++;
				for (int t = p; t < NUM_TABLES; t++) begin
					i = model_index(t, pc);
					m_u[t][i] = sat2(m_u[t][i], 1'b0);
				end
			end
		end
		m_ghist = {m_ghist[30:0], taken};
	endtask

	function automatic logic ack_value(logic on_lookup);
		return on_lookup ? lookup_ack : update_ack;
	endfunction

	task automatic wait_ack(input logic on_lookup, input logic level);
		int cycles;
		cycles = 0;
		while (ack_value(on_lookup) != level && cycles < WAIT_LIMIT) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (ack_value(on_lookup) != level) begin
			timeout_count++;
			$display("%0t: %s ack never went to %0d", $time, on_lookup ? "lookup" : "update",
				level);
		end
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		lookup_req = 1'b0;
		update_req = 1'b0;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
		m_ghist = '0;
		for (int t = 0; t < NUM_TABLES; t++) begin
			for (int i = 0; i < TAGGED_ENTRIES; i++) begin
				m_valid[t][i] = 1'b0;
				m_tag[t][i] = '0;
				m_ctr[t][i] = '0;
				m_u[t][i] = '0;
			end
		end
		for (int i = 0; i < BASE_ENTRIES; i++) begin
			m_base[i] = 2'b01;
		end
		assert (lookup_ack == 1'b0) else report_value("lookup_ack", 32'd0, 32'(lookup_ack));
		assert (update_ack == 1'b0) else report_value("update_ack", 32'd0, 32'(update_ack));
	endtask

	task automatic do_lookup(input pc_t pc, input int hold);
		logic atk;
		if (timeout_count != 0) begin
			return;
		end
		model_select(pc, exp_provider, exp_taken, atk);
		lookup_pc = pc;
		lookup_req = 1'b1;
		wait_ack(1'b1, 1'b1);
		if (timeout_count != 0) begin
			return;
		end
		repeat (hold) begin
			@(posedge clk);
			#1;
		end
		lookup_req = 1'b0;
		lookups_checked++;
		wait_ack(1'b1, 1'b0);
	endtask

	task automatic do_update(input pc_t pc, input logic taken, input int hold);
		if (timeout_count != 0) begin
			return;
		end
		update_pc = pc;
		update_taken = taken;
		update_req = 1'b1;
		wait_ack(1'b0, 1'b1);
		if (timeout_count != 0) begin
			return;
		end
		model_update(pc, taken);
		repeat (hold) begin
			@(posedge clk);
			#1;
		end
		update_req = 1'b0;
		wait_ack(1'b0, 1'b0);
	endtask

	// prediction against the model
	assert property (@(posedge clk) disable iff (reset)
		$rose(lookup_ack) |-> pred_taken == exp_taken)
		else report_value("pred_taken", 32'(exp_taken), 32'(pred_taken));

	assert property (@(posedge clk) disable iff (reset)
		$rose(lookup_ack) |-> pred_provider == exp_provider)
		else report_value("pred_provider", 32'(exp_provider), 32'(pred_provider));

	// handshake timing
	assert property (@(posedge clk) disable iff (reset)
		$rose(lookup_ack) |-> $past(lookup_req, 3) && !$past(lookup_req, 4))
		else report_text("lookup_ack did not rise three cycles after lookup_req");

	assert property (@(posedge clk) disable iff (reset)
		$rose(update_ack) |-> $past(update_req, 4) && !$past(update_req, 5))
		else report_text("update_ack did not rise four cycles after update_req");

	assert property (@(posedge clk) disable iff (reset)
		$rose(lookup_ack) |-> $past(lookup_req))
		else report_text("lookup_ack rose without lookup_req");

	assert property (@(posedge clk) disable iff (reset)
		$rose(update_ack) |-> $past(update_req))
		else report_text("update_ack rose without update_req");

	assert property (@(posedge clk) disable iff (reset)
		lookup_ack && lookup_req |=> lookup_ack)
		else report_text("lookup_ack dropped while lookup_req was held");

	assert property (@(posedge clk) disable iff (reset)
		lookup_ack && !lookup_req |=> !lookup_ack)
		else report_text("lookup_ack stayed high after lookup_req dropped");

	assert property (@(posedge clk) disable iff (reset)
		update_ack && update_req |=> update_ack)
		else report_text("update_ack dropped while update_req was held");

	assert property (@(posedge clk) disable iff (reset)
		update_ack && !update_req |=> !update_ack)
		else report_text("update_ack stayed high after update_req dropped");

	initial begin
		logic [31:0] r;
		pc_t pc;
		error_count = 0;
		timeout_count = 0;
		lookups_checked = 0;
		alloc_count = 0;
		decay_count = 0;
		rng_state = 32'h540;
		exp_taken = 1'b0;
		exp_provider = '0;
		reset = 1'b1;
		lookup_req = 1'b0;
		lookup_pc = '0;
		update_req = 1'b0;
		update_pc = '0;
		update_taken = 1'b0;
		for (int k = 0; k < POOL_SIZE; k++) begin
			r = next_rand();
			pc_pool[k] = pc_t'(r >> 12);
		end

		apply_reset();
		for (int n = 0; n < 8; n++) begin
			r = next_rand();
			do_lookup(pc_t'(r >> 16), 0);
		end

		// base learns taken
		apply_reset();
		do_update(16'h1a2b, 1'b1, 0);
		do_update(16'h1a2b, 1'b1, 1);
		do_lookup(16'h1a2b, 0);

		// saturate the history with ones so the allocating update keeps it
		apply_reset();
		for (int n = 0; n < 32; n++) begin
			do_update(16'h0a3c, 1'b1, 0);
		end
		do_update(16'h5bc1, 1'b1, 0);
		do_lookup(16'h5bc1, 2);

		// short repeating pattern, u builds up until allocation fails
		for (int n = 0; n < 120; n++) begin
			pc = (n % 2 == 0) ? 16'h5bc1 : 16'h0a3c;
			do_update(pc, (n % 5) != 2 && (n % 5) != 4, 0);
			do_lookup(pc, 0);
		end

		for (int n = 0; n < 600; n++) begin
			r = next_rand();
			pc = pc_pool[int'(r[19:16]) % POOL_SIZE];
			if (r[31]) begin
				do_lookup(pc, int'(r[25:24]));
			end else begin
				do_update(pc, (r[29:26] < 4'd12) ^ pc[0], int'(r[23:22]));
			end
		end

		$display("lookups %0d, allocations %0d, decays %0d, errors %0d, timeouts %0d",
			lookups_checked, alloc_count, decay_count, error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* files.f */
common/tage_pkg.sv
design/tage_index_gen.sv
tage_table/tage_tagged_table.sv
design/tage_base_table.sv
design/tage_provider_select.sv
design/tage_update_ctrl.sv
design/tage_top.sv
verif/tage_tb.sv

/* run.sh */
#!/bin/sh

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f files.f \
	--top-module tage_tb -o tage_sim; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/tage_sim 2>&1)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation passed"; then
	exit 0
fi

echo "pass message not found"
exit 1
